//--- hdl/srl_pkg.sv
`default_nettype none

package srl_pkg;

    parameter int DATA_W  = 16;   // Data, LFSR and MISR width
    parameter int COUNT_W = 16;   // Width of num_words

    // Polynomial mask shared by pattern LFSR and MISR
    parameter logic [DATA_W-1:0] LFSR_POLY = 16'h1021;
    parameter logic [DATA_W-1:0] LFSR_SEED = 16'hace1;

    typedef enum logic {
        OP_PASS = 1'b0,   // External words through the line
        OP_BIST = 1'b1    // Self-test run
    } srl_op_e;

    typedef enum logic [1:0] {
        GEN_IDLE  = 2'd0,
        GEN_FILL  = 2'd1,
        GEN_FLUSH = 2'd2
    } gen_state_e;

    // One MISR step; with word of zero it is the plain LFSR step
    function automatic logic [DATA_W-1:0] misr_next(
        input logic [DATA_W-1:0] cur,
        input logic [DATA_W-1:0] word
    );
        logic [DATA_W-1:0] nxt;
        nxt = {cur[DATA_W-2:0], 1'b0};
        if (cur[DATA_W-1]) begin
            nxt = nxt ^ LFSR_POLY;
        end
        return nxt ^ word;
    endfunction

endpackage

`default_nettype wire

//--- hdl/pattern_gen.sv
`timescale 1ns/100ps
`default_nettype none

module pattern_gen #(
    parameter int DEPTH = 8
) (
    input  wire                               clk,
    input  wire                               er,
    input  wire srl_pkg::srl_op_e             op,
    input  wire [srl_pkg::DATA_W-1:0]         ext_data,
    input  wire                               ext_valid,
    input  wire                               start,
    input  wire [srl_pkg::COUNT_W-1:0]        num_words,
    output logic [srl_pkg::DATA_W-1:0]        shift_data,
    output logic                              shift_en,
    output logic                              busy,
    output logic                              run_clear,
    output logic                              run_absorb,
    output logic                              run_last
);
    import srl_pkg::*;

    // Counter must hold both num_words and DEPTH
    localparam int CNT_W = (COUNT_W > $clog2(DEPTH + 1)) ? COUNT_W : $clog2(DEPTH + 1);

    gen_state_e         state;
    logic [CNT_W-1:0]   cnt;        // Cycles left in current phase
    logic [DATA_W-1:0]  lfsr;
    logic               start_ok;
    logic               cnt_last;

    assign start_ok = (state == GEN_IDLE) && (op == OP_BIST) && start;
    assign cnt_last = (cnt == CNT_W'(1));

    always_ff @(posedge clk or posedge er) begin
        if (er) begin
            state     <= GEN_IDLE;
            cnt       <= '0;
            lfsr      <= LFSR_SEED;
            run_clear <= 1'b0;
        end else begin
            run_clear <= start_ok;   // First cycle of a run
            case (state)
                GEN_IDLE: begin
                    if (start_ok) begin
                        lfsr <= LFSR_SEED;
                        if (num_words == '0) begin
                            state <= GEN_FLUSH;   // Nothing to fill
                            cnt   <= CNT_W'(DEPTH);
                        end else begin
                            state <= GEN_FILL;
                            cnt   <= CNT_W'(num_words);
                        end
                    end
                end
                GEN_FILL: begin
                    lfsr <= misr_next(lfsr, '0);
                    if (cnt_last) begin
                        state <= GEN_FLUSH;
                        cnt   <= CNT_W'(DEPTH);
                    end else begin
                        cnt <= cnt - CNT_W'(1);
                    end
                end
                GEN_FLUSH: begin
                    if (cnt_last) begin
                        state <= GEN_IDLE;
                    end
                    cnt <= cnt - CNT_W'(1);
                end
                default: begin
                    state <= GEN_IDLE;
                end
            endcase
        end
    end

    assign busy       = (state != GEN_IDLE);
    assign run_absorb = busy;   // Line shifts on every run cycle
    assign run_last   = (state == GEN_FLUSH) && cnt_last;

    always_comb begin
        case (state)
            GEN_FILL: begin
                shift_data = lfsr;
                shift_en   = 1'b1;
            end
            GEN_FLUSH: begin
                shift_data = '0;
                shift_en   = 1'b1;
            end
            default: begin
                // Pass-through only when idle in OP_PASS
                shift_data = ext_data;
                shift_en   = (op == OP_PASS) && ext_valid;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/delay_line.sv
`timescale 1ns/100ps
`default_nettype none

module delay_line #(
    parameter int DEPTH = 8
) (
    input  wire                               clk,
    input  wire                               er,
    input  wire                               shift_en,
    input  wire [srl_pkg::DATA_W-1:0]         shift_data,
    input  wire [$clog2(DEPTH)-1:0]           tap,
    output logic [srl_pkg::DATA_W-1:0]        tap_data
);
    import srl_pkg::*;

    localparam int TAP_W = $clog2(DEPTH);

    logic [DATA_W-1:0] stage [DEPTH];
    logic              tap_over;

    // Stage 0 takes the new word, the rest move one further
    always_ff @(posedge clk or posedge er) begin
        if (er) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else if (shift_en) begin
            stage[0] <= shift_data;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // Only reachable when DEPTH is not a power of two
    assign tap_over = ({1'b0, tap} >= (TAP_W + 1)'(DEPTH));

    always_comb begin
        if (tap_over) begin
            tap_data = stage[DEPTH-1];   // Clamp to last stage
        end else begin
            tap_data = stage[tap];
        end
    end

endmodule

`default_nettype wire

//--- hdl/signature_compactor.sv
`timescale 1ns/100ps
`default_nettype none

module signature_compactor (
    input  wire                               clk,
    input  wire                               er,
    input  wire                               run_clear,
    input  wire                               run_absorb,
    input  wire                               run_last,
    input  wire [srl_pkg::DATA_W-1:0]         tap_data,
    output logic [srl_pkg::DATA_W-1:0]        signature,
    output logic                              done
);
    import srl_pkg::*;

    logic [DATA_W-1:0] misr_base;

    // A new run starts from an empty register
    assign misr_base = run_clear ? '0 : signature;

    always_ff @(posedge clk or posedge er) begin
        if (er) begin
            signature <= '0;
            done      <= 1'b0;
        end else begin
            done <= run_last;   // One cycle after last word
            if (run_absorb) begin
                signature <= misr_next(misr_base, tap_data);
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/srl_bist_top.sv
`timescale 1ns/100ps
`default_nettype none

module srl_bist_top #(
    parameter int DEPTH = 8
) (
    input  wire                               clk,
    input  wire                               er,
    input  wire srl_pkg::srl_op_e             op,
    input  wire [srl_pkg::DATA_W-1:0]         ext_data,
    input  wire                               ext_valid,
    input  wire [$clog2(DEPTH)-1:0]           tap,
    input  wire                               start,
    input  wire [srl_pkg::COUNT_W-1:0]        num_words,
    output logic [srl_pkg::DATA_W-1:0]        dout,
    output logic                              busy,
    output logic                              done,
    output logic [srl_pkg::DATA_W-1:0]        signature
);
    import srl_pkg::*;

    logic [DATA_W-1:0] shift_data;
    logic [DATA_W-1:0] tap_data;
    logic              shift_en;
    logic              gen_busy;
    logic              run_clear;
    logic              run_absorb;
    logic              run_last;

    pattern_gen #(
        .DEPTH      (DEPTH)
    ) u_pattern_gen (
        .clk        (clk),
        .er         (er),
        .op         (op),
        .ext_data   (ext_data),
        .ext_valid  (ext_valid),
        .start      (start),
        .num_words  (num_words),
        .shift_data (shift_data),
        .shift_en   (shift_en),
        .busy       (gen_busy),
        .run_clear  (run_clear),
        .run_absorb (run_absorb),
        .run_last   (run_last)
    );

    delay_line #(
        .DEPTH      (DEPTH)
    ) u_delay_line (
        .clk        (clk),
        .er         (er),
        .shift_en   (shift_en),
        .shift_data (shift_data),
        .tap        (tap),
        .tap_data   (tap_data)
    );

    // Sees the tap word before each shift
    signature_compactor u_signature_compactor (
        .clk        (clk),
        .er         (er),
        .run_clear  (run_clear),
        .run_absorb (run_absorb),
        .run_last   (run_last),
        .tap_data   (tap_data),
        .signature  (signature),
        .done       (done)
    );

    assign dout = tap_data;
    assign busy = gen_busy;

endmodule

`default_nettype wire

//--- verif/tb_srl_bist.sv
`timescale 1ns/100ps
`default_nettype none

module tb_srl_bist;
    import srl_pkg::*;

    localparam int DEPTH        = 8;
    localparam int TAP_W        = $clog2(DEPTH);
    localparam int DONE_TIMEOUT = 200;   // Cycles

    logic                clk;
    logic                er;
    srl_op_e             op;
    logic [DATA_W-1:0]   ext_data;
    logic                ext_valid;
    logic [TAP_W-1:0]    tap;
    logic                start;
    logic [COUNT_W-1:0]  num_words;
    logic [DATA_W-1:0]   dout;
    logic                busy;
    logic                done;
    logic [DATA_W-1:0]   signature;

    logic [DATA_W-1:0]   line_model [DEPTH];   // Stage 0 is the newest word
    logic [31:0]         rand_state;

    srl_bist_top #(
        .DEPTH     (DEPTH)
    ) dut (
        .clk       (clk),
        .er        (er),
        .op        (op),
        .ext_data  (ext_data),
        .ext_valid (ext_valid),
        .tap       (tap),
        .start     (start),
        .num_words (num_words),
        .dout      (dout),
        .busy      (busy),
        .done      (done),
        .signature (signature)
    );

    always #5 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = rand_state[31] ^ rand_state[21] ^ rand_state[1] ^ rand_state[0];
            rand_state = {rand_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [DATA_W-1:0] misr_model(
        input logic [DATA_W-1:0] cur,
        input logic [DATA_W-1:0] word
    );
        logic [DATA_W-1:0] nxt;
        nxt = cur << 1;
        if (cur[DATA_W-1] == 1'b1) begin
            nxt = nxt ^ LFSR_POLY;
        end
        return nxt ^ word;
    endfunction

    function automatic logic [DATA_W-1:0] lfsr_model(input logic [DATA_W-1:0] cur);
        logic [DATA_W-1:0] nxt;
        nxt = cur << 1;
        if (cur[DATA_W-1] == 1'b1) begin
            nxt = nxt ^ LFSR_POLY;
        end
        return nxt;
    endfunction

    function automatic void line_shift(input logic [DATA_W-1:0] word);
        for (int i = DEPTH - 1; i > 0; i--) begin
            line_model[i] = line_model[i-1];
        end
        line_model[0] = word;
    endfunction

    task automatic abort_sim();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(
        input string             name,
        input logic [DATA_W-1:0] got,
        input logic [DATA_W-1:0] exp
    );
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            abort_sim();
        end
    endtask

    task automatic check_flag(
        input string name,
        input logic  got,
        input logic  exp
    );
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            abort_sim();
        end
    endtask

    // Outputs are read here, before new inputs go out
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic fill_line(input int count);
        op        = OP_PASS;
        ext_valid = 1'b1;
        for (int n = 0; n < count; n++) begin
            ext_data = DATA_W'(rand_bits(DATA_W));
            next_cycle();
            line_shift(ext_data);
        end
        ext_valid = 1'b0;
    endtask

    task automatic test_reset_state();
        for (int t = 0; t < DEPTH; t++) begin
            tap = TAP_W'(t);
            next_cycle();
            check_data("dout", dout, '0);
            check_flag("busy", busy, 1'b0);
            check_flag("done", done, 1'b0);
        end
    endtask

    task automatic pass_run(input logic [TAP_W-1:0] tap_sel, input int count);
        logic              valid;
        logic [DATA_W-1:0] word;
        op  = OP_PASS;
        tap = tap_sel;
        for (int n = 0; n < count; n++) begin
            valid     = (rand_bits(2) != 32'd0);   // Roughly one gap in four
            word      = DATA_W'(rand_bits(DATA_W));
            ext_data  = word;
            ext_valid = valid;
            next_cycle();
            if (valid) begin
                line_shift(word);
            end
            check_data("dout", dout, line_model[tap_sel]);
            check_flag("busy", busy, 1'b0);
        end
        ext_valid = 1'b0;
    endtask

    task automatic test_pass_through();
        pass_run('0, 40);
        pass_run(TAP_W'(DEPTH / 2), 40);
        pass_run(TAP_W'(DEPTH - 1), 40);
    endtask

    task automatic test_tap_sweep();
        fill_line(DEPTH);
        for (int t = 0; t < DEPTH; t++) begin
            tap = TAP_W'(t);
            next_cycle();
            check_data("dout", dout, line_model[t]);
        end
    endtask

    // extra_start is the cycle after start that gets a second pulse, 0 for none
    task automatic run_bist(
        input logic [COUNT_W-1:0] words,
        input logic [TAP_W-1:0]   tap_sel,
        input int                 extra_start
    );
        logic [DATA_W-1:0] exp_sig;
        logic [DATA_W-1:0] lfsr;
        int                total;
        int                cycles;
        logic              seen;

        exp_sig = '0;
        lfsr    = LFSR_SEED;
        total   = int'(words) + DEPTH;
        for (int c = 0; c < total; c++) begin
            exp_sig = misr_model(exp_sig, line_model[tap_sel]);   // Word before the shift
            if (c < int'(words)) begin
                line_shift(lfsr);
                lfsr = lfsr_model(lfsr);
            end else begin
                line_shift('0);
            end
        end

        op        = OP_BIST;
        tap       = tap_sel;
        num_words = words;
        ext_valid = 1'b0;
        start     = 1'b1;
        next_cycle();
        start  = 1'b0;
        cycles = 1;
        seen   = 1'b0;
        while (!seen && cycles <= DONE_TIMEOUT) begin
            check_flag("busy", busy, cycles <= total);
            if (done) begin
                seen = 1'b1;
            end else begin
                start = (cycles == extra_start);
                next_cycle();
                cycles++;
            end
        end
        start = 1'b0;

        if (!seen) begin
            $display("Timeout: done never arrived within %0d cycles of start", DONE_TIMEOUT);
            abort_sim();
        end else begin
            if (cycles != total + 1) begin
                $display("done arrived %0d cycles after start instead of %0d",
                         cycles, total + 1);
                abort_sim();
            end
            check_data("signature", signature, exp_sig);
            next_cycle();
            check_flag("done", done, 1'b0);   // Single-cycle pulse
            check_flag("busy", busy, 1'b0);
            check_data("signature", signature, exp_sig);
        end
    endtask

    task automatic test_bist_signature();
        logic [COUNT_W-1:0] words;
        logic [TAP_W-1:0]   tap_sel;
        words   = COUNT_W'((rand_bits(6) % 40) + 1);
        tap_sel = TAP_W'(rand_bits(TAP_W));
        $display("BIST run with %0d words at tap %0d", words, tap_sel);
        run_bist(words, tap_sel, 0);
    endtask

    task automatic test_zero_count();
        logic [TAP_W-1:0] tap_sel;
        fill_line(DEPTH);   // Line must hold data so the flush is not all zeros
        tap_sel = TAP_W'(rand_bits(TAP_W));
        run_bist('0, tap_sel, 3);
        fill_line(DEPTH);
        run_bist(COUNT_W'(12), TAP_W'(DEPTH - 1), 5);
    endtask

    task automatic test_back_to_back();
        logic [COUNT_W-1:0] words_a;
        logic [COUNT_W-1:0] words_b;
        logic [TAP_W-1:0]   tap_a;
        fill_line(DEPTH);
        words_a = COUNT_W'((rand_bits(6) % 40) + 1);
        words_b = COUNT_W'((rand_bits(6) % 40) + 1);
        tap_a   = TAP_W'(rand_bits(TAP_W));
        run_bist(words_a, tap_a, 0);
        run_bist(words_b, tap_a + TAP_W'(1), 0);
    endtask

    initial begin
        clk        = 1'b0;
        er         = 1'b1;
        op         = OP_PASS;
        ext_data   = '0;
        ext_valid  = 1'b0;
        tap        = '0;
        start      = 1'b0;
        num_words  = '0;
        rand_state = 32'hc46b_46cd;
        for (int i = 0; i < DEPTH; i++) begin
            line_model[i] = '0;
        end

        repeat (8) @(posedge clk);
        #1;
        er = 1'b0;

        $display("Test: reset state");
        test_reset_state();
        $display("Test: pass-through delay");
        test_pass_through();
        $display("Test: tap sweep");
        test_tap_sweep();
        $display("Test: BIST signature");
        test_bist_signature();
        $display("Test: zero count and ignored start");
        test_zero_count();
        $display("Test: back-to-back runs");
        test_back_to_back();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hdl/srl_pkg.sv
hdl/pattern_gen.sv
hdl/delay_line.sv
hdl/signature_compactor.sv
hdl/srl_bist_top.sv
verif/tb_srl_bist.sv

//--- Makefile
SIM    := verilator
FLAGS  := --binary --timing --timescale 1ns/100ps -j 0
TOP    := tb_srl_bist
FLIST  := compile.f
OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

# Status comes from the pass line, not from the simulator exit code
run: compile
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)
